/* common/lane_pkg.sv */
/* Shared sizes, opcodes and bus structs for the two-lane vector slice.
   Every RTL module takes these by a wildcard import in its header. */

package lane_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int num_lanes  = 2;
	localparam int data_width = 16;
	localparam int num_regs   = 8;
	localparam int mem_depth  = 64;

	localparam int reg_bits  = $clog2(num_regs);
	localparam int addr_bits = $clog2(mem_depth);
	localparam int lane_bits = (num_lanes > 1) ? $clog2(num_lanes) : 1;

	typedef logic [data_width-1:0] data_t;
	typedef logic [reg_bits-1:0]   reg_idx_t;
	typedef logic [addr_bits-1:0]  addr_t;
	typedef logic [num_lanes-1:0]  lane_vec_t;
	typedef logic [lane_bits-1:0]  lane_idx_t;

	////////////////////////////////////////////////////////////
	// Commands
	////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		op_nop,
		op_li,
		op_add,
		op_sub,
		op_and,
		op_xor,
		op_ld,
		op_st
	} opcode_e;

	// One broadcast instruction
	typedef struct packed {
		opcode_e  op;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		data_t    imm;
	} command_t;

	// One access toward the shared memory
	typedef struct packed {
		logic  we;
		addr_t addr;
		data_t wdata;
	} mem_req_t;

	// Load/store sequencing inside a lane
	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_wait
	} exec_state_e;

endpackage

/* lane/lane_regfile.sv */
/* Register file of one lane with two combinational reads and one write.
   Reads during a write see the old contents. */

`timescale 1ns/1ns

module lane_regfile
	import lane_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     we,
	input  reg_idx_t wr_idx,
	input  data_t    wr_data,
	input  reg_idx_t rd_idx1,
	input  reg_idx_t rd_idx2,
	output data_t    rd_data1,
	output data_t    rd_data2
);

	data_t regs [num_regs];

	// Write port
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end
		else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Read ports
	assign rd_data1 = regs[rd_idx1];
	assign rd_data2 = regs[rd_idx2];

endmodule

/* lane/lane_exec.sv */
/* Execute stage of a lane. ALU results come out in the same cycle,
   loads and stores go through the memory arbiter and finish later. */

`timescale 1ns/1ns

module lane_exec
	import lane_pkg::*;
#(
	parameter int lane_id = 0
)(
	input  logic     clock,
	input  logic     reset,
	input  logic     valid,
	input  opcode_e  op,
	input  data_t    opa,
	input  data_t    opb,
	input  data_t    imm,
	output logic     mem_req,
	output mem_req_t mem_req_data,
	input  logic     grant,
	input  data_t    rdata,
	output logic     done,
	output data_t    result,
	output logic     busy
);

	exec_state_e state;
	mem_req_t    req_q;
	data_t       alu_result;
	data_t       mem_addr;
	logic        is_mem;

	assign is_mem   = (op == op_ld) || (op == op_st);
	assign mem_addr = opa + imm;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (op)
			// Thread value differs per lane
			op_li:   alu_result = imm + data_t'(lane_id);
			op_add:  alu_result = opa + opb;
			op_sub:  alu_result = opa - opb;
			op_and:  alu_result = opa & opb;
			op_xor:  alu_result = opa ^ opb;
			default: alu_result = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Load/store FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end
		else begin
			case (state)
				st_idle: if (valid && is_mem) state <= st_req;
				st_req:  if (grant) state <= req_q.we ? st_idle : st_wait;
				default: state <= st_idle;
			endcase
		end
	end

	// Request held stable until granted
	always_ff @(posedge clock) begin
		if (state == st_idle && valid && is_mem) begin
			req_q.we    <= (op == op_st);
			req_q.addr  <= addr_t'(mem_addr);
			req_q.wdata <= opb;
		end
	end

	assign mem_req      = (state == st_req);
	assign mem_req_data = req_q;
	assign busy         = (state != st_idle) || (valid && is_mem);

	always_comb begin
		case (state)
			st_idle: begin
				done   = valid && !is_mem;
				result = alu_result;
			end
			st_req: begin
				done   = grant && req_q.we;
				result = req_q.wdata;
			end
			st_wait: begin
				// Read data arrives one cycle after the grant
				done   = 1'b1;
				result = rdata;
			end
			default: begin
				done   = 1'b0;
				result = '0;
			end
		endcase
	end

endmodule

/* lane/lane_unit.sv */
/* One SIMT lane. Captures the broadcast command, reads its own registers,
   executes and writes back, then reports each finished command by commit. */

`timescale 1ns/1ns

module lane_unit
	import lane_pkg::*;
#(
	parameter int lane_id = 0
)(
	input  logic     clock,
	input  logic     reset,
	input  logic     cmd_valid,
	input  command_t cmd,
	output logic     mem_req,
	output mem_req_t mem_req_data,
	input  logic     grant,
	input  data_t    rdata,
	output logic     commit,
	output data_t    commit_data,
	output logic     busy
);

	command_t cmd_q;
	logic     valid_q;

	data_t    src_data1;
	data_t    src_data2;

	logic     exec_done;
	data_t    exec_result;
	logic     wb_en;

	////////////////////////////////////////////////////////////
	// Command capture
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end
		else begin
			valid_q <= cmd_valid;
		end
	end

	// Held until the next command so dst stays valid for loads
	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			cmd_q <= cmd;
		end
	end

	////////////////////////////////////////////////////////////
	// Register read and write-back
	////////////////////////////////////////////////////////////
	// Stores and nops leave the registers alone
	assign wb_en = exec_done && (cmd_q.op != op_st) && (cmd_q.op != op_nop);

	lane_regfile regfile_i (
		.clock    (clock),
		.reset    (reset),
		.we       (wb_en),
		.wr_idx   (cmd_q.dst),
		.wr_data  (exec_result),
		.rd_idx1  (cmd_q.src1),
		.rd_idx2  (cmd_q.src2),
		.rd_data1 (src_data1),
		.rd_data2 (src_data2)
	);

	////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////
	lane_exec #(
		.lane_id (lane_id)
	) exec_i (
		.clock        (clock),
		.reset        (reset),
		.valid        (valid_q),
		.op           (cmd_q.op),
		.opa          (src_data1),
		.opb          (src_data2),
		.imm          (cmd_q.imm),
		.mem_req      (mem_req),
		.mem_req_data (mem_req_data),
		.grant        (grant),
		.rdata        (rdata),
		.done         (exec_done),
		.result       (exec_result),
		.busy         (busy)
	);

	// Commit pulse, registered alongside the write-back
	always_ff @(posedge clock) begin
		if (reset) begin
			commit      <= 1'b0;
			commit_data <= '0;
		end
		else begin
			commit      <= exec_done;
			commit_data <= exec_result;
		end
	end

endmodule

/* source/mem_arbiter.sv */
/* Round-robin arbiter that shares the single data memory port
   between the lanes. Grants are combinational, one lane per cycle. */

`timescale 1ns/1ns

module mem_arbiter
	import lane_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  lane_vec_t req,
	input  mem_req_t  req_data [num_lanes],
	output lane_vec_t grant,
	output mem_req_t  mem_out,
	output logic      mem_en
);

	lane_idx_t last_q;
	lane_idx_t win;

	// Search starts at the lane after the last winner
	always_comb begin
		int   idx;
		logic found;
		grant = '0;
		win   = last_q;
		found = 1'b0;
		for (int i = 1; i <= num_lanes; i++) begin
			idx = (int'(last_q) + i) % num_lanes;
			if (req[idx] && !found) begin
				grant[idx] = 1'b1;
				win        = lane_idx_t'(idx);
				found      = 1'b1;
			end
		end
	end

	// Pointer moves only on a grant
	always_ff @(posedge clock) begin
		if (reset) begin
			last_q <= lane_idx_t'(num_lanes - 1);
		end
		else if (|grant) begin
			last_q <= win;
		end
	end

	assign mem_out = req_data[win];
	assign mem_en  = |grant;

endmodule

/* source/data_mem.sv */
/* Shared data memory. Writes take effect at the clock edge and
   read data is registered, so it appears the cycle after the access. */

`timescale 1ns/1ns

module data_mem
	import lane_pkg::*;
(
	input  logic     clock,
	input  logic     mem_en,
	input  mem_req_t mem_in,
	output data_t    rdata
);

	data_t mem [mem_depth];

	initial begin
		for (int i = 0; i < mem_depth; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clock) begin
		if (mem_en && mem_in.we) begin
			mem[mem_in.addr] <= mem_in.wdata;
		end
	end

	// Registered read port
	always_ff @(posedge clock) begin
		if (mem_en) begin
			rdata <= mem[mem_in.addr];
		end
	end

endmodule

/* source/vector_top.sv */
/* Top of the vector slice. Broadcasts the host command to every lane
   and shares one data memory between them through the arbiter. */

`timescale 1ns/1ns

module vector_top
	import lane_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      cmd_valid,
	input  command_t  cmd,
	output lane_vec_t commit,
	output data_t     commit_data [num_lanes],
	output logic      busy
);

	lane_vec_t mem_req;
	lane_vec_t grant;
	lane_vec_t lane_busy;
	mem_req_t  req_data [num_lanes];
	mem_req_t  mem_out;
	logic      mem_en;
	data_t     rdata;

	////////////////////////////////////////////////////////////
	// Lanes
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		lane_unit #(
			.lane_id (i)
		) lane_i (
			.clock        (clock),
			.reset        (reset),
			.cmd_valid    (cmd_valid),
			.cmd          (cmd),
			.mem_req      (mem_req[i]),
			.mem_req_data (req_data[i]),
			.grant        (grant[i]),
			.rdata        (rdata),
			.commit       (commit[i]),
			.commit_data  (commit_data[i]),
			.busy         (lane_busy[i])
		);
	end

	assign busy = |lane_busy;

	////////////////////////////////////////////////////////////
	// Shared memory
	////////////////////////////////////////////////////////////
	mem_arbiter arbiter_i (
		.clock    (clock),
		.reset    (reset),
		.req      (mem_req),
		.req_data (req_data),
		.grant    (grant),
		.mem_out  (mem_out),
		.mem_en   (mem_en)
	);

	data_mem mem_i (
		.clock  (clock),
		.mem_en (mem_en),
		.mem_in (mem_out),
		.rdata  (rdata)
	);

endmodule

/* bench/vector_chk.sv */
/* Concurrent checks bound into the memory arbiter and into every lane.
   Ports that a target lacks are tied off in its bind. */

`timescale 1ns/1ns

module vector_chk
	import lane_pkg::*;
(
	input logic      clock,
	input logic      reset,
	input lane_vec_t req,
	input lane_vec_t grant,
	input logic      cmd_valid,
	input logic      commit
);

	// At most one lane owns the memory port
	grant_onehot: assert property (
		@(posedge clock) disable iff (reset) $onehot0(grant)
	) else $error("Arbiter granted more than one lane: %b", grant);

	grant_to_requester: assert property (
		@(posedge clock) disable iff (reset) (grant & ~req) == '0
	) else $error("Arbiter granted an idle lane: grant %b req %b", grant, req);

	// A commit held twice needs a new command behind it
	commit_pulse: assert property (
		@(posedge clock) disable iff (reset) (commit && $past(commit)) |-> $past(cmd_valid, 2)
	) else $error("Commit stayed high for two cycles without a new command");

endmodule

bind mem_arbiter vector_chk arbiter_chk_i (
	.clock     (clock),
	.reset     (reset),
	.req       (req),
	.grant     (grant),
	.cmd_valid (1'b0),
	.commit    (1'b0)
);

bind lane_unit vector_chk lane_chk_i (
	.clock     (clock),
	.reset     (reset),
	.req       ('0),
	.grant     ('0),
	.cmd_valid (cmd_valid),
	.commit    (commit)
);

/* bench/vector_tb.sv */
/* Directed testbench for the two-lane vector slice. It keeps its own model
   of the lane registers and the shared memory and checks every commit. */

`timescale 1ns/1ns

module vector_tb
	import lane_pkg::*;
();

	// The tests take about 230 cycles
	localparam int timeout_cycles = 2000;
	localparam int mem_wait_limit = 20;

	logic      clock;
	logic      reset;
	logic      cmd_valid;
	command_t  cmd;
	lane_vec_t commit;
	data_t     commit_data [num_lanes];
	logic      busy;

	data_t  model_regs [num_lanes][num_regs];
	data_t  model_mem [mem_depth];
	integer seed;
	int     error_count;
	int     test_count;
	int     cycle_count = 0;

	vector_top dut_i (
		.clock       (clock),
		.reset       (reset),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.commit      (commit),
		.commit_data (commit_data),
		.busy        (busy)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Model and checking helpers
	////////////////////////////////////////////////////////////
	function automatic data_t expect_alu(int lane, opcode_e op, data_t a, data_t b, data_t imm);
		case (op)
			op_li:   return imm + data_t'(lane);
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_xor:  return a ^ b;
			default: return '0;
		endcase
	endfunction

	function automatic command_t make_cmd(opcode_e op, int dst, int src1, int src2, data_t imm);
		command_t c;
		c.op   = op;
		c.dst  = reg_idx_t'(dst);
		c.src1 = reg_idx_t'(src1);
		c.src2 = reg_idx_t'(src2);
		c.imm  = imm;
		return c;
	endfunction

	function automatic opcode_e random_alu_op();
		case ($unsigned($random(seed)) % 4)
			0:       return op_add;
			1:       return op_sub;
			2:       return op_and;
			default: return op_xor;
		endcase
	endfunction

	task automatic check_value(string name, int lane, data_t expected, data_t actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s lane %0d: expected %h, actual %h", name, lane, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_cond(string name, bit cond, string what);
		assert (cond) else begin
			$display("[ERROR] %s: %s", name, what);
			error_count++;
		end
	endtask

	task automatic finish_test(string name, int start_errors);
		test_count++;
		$display("Test %s done with %0d errors", name, error_count - start_errors);
	endtask

	// Called on a falling edge
	task automatic send_cmd(command_t c);
		cmd_valid = 1'b1;
		cmd       = c;
	endtask

	// ALU, li or nop with its fixed one-cycle commit
	task automatic run_alu(string name, command_t c);
		data_t expected [num_lanes];
		for (int l = 0; l < num_lanes; l++) begin
			expected[l] = expect_alu(l, c.op, model_regs[l][c.src1], model_regs[l][c.src2], c.imm);
		end
		@(negedge clock);
		send_cmd(c);
		@(negedge clock);
		cmd_valid = 1'b0;
		check_cond(name, commit == '0, "commit came before the result was ready");
		@(negedge clock);
		check_cond(name, commit == '1, "commit missing one cycle after the command");
		for (int l = 0; l < num_lanes; l++) begin
			check_value(name, l, expected[l], commit_data[l]);
			if (c.op != op_nop) begin
				model_regs[l][c.dst] = expected[l];
			end
		end
	endtask

	// Load or store that waits for every lane to commit
	task automatic run_mem(string name, command_t c);
		data_t     expected [num_lanes];
		addr_t     addr [num_lanes];
		lane_vec_t done_lanes;
		int        waited;
		for (int l = 0; l < num_lanes; l++) begin
			addr[l]     = addr_t'(model_regs[l][c.src1] + c.imm);
			expected[l] = (c.op == op_st) ? model_regs[l][c.src2] : model_mem[addr[l]];
		end
		@(negedge clock);
		send_cmd(c);
		@(negedge clock);
		cmd_valid  = 1'b0;
		done_lanes = '0;
		waited     = 0;
		while (done_lanes != '1 && waited < mem_wait_limit) begin
			for (int l = 0; l < num_lanes; l++) begin
				if (commit[l]) begin
					check_cond(name, !done_lanes[l], "a lane committed twice for one command");
					check_value(name, l, expected[l], commit_data[l]);
					done_lanes[l] = 1'b1;
				end
			end
			if (done_lanes != '1) begin
				check_cond(name, busy, "busy dropped before every lane committed");
			end
			else begin
				check_cond(name, !busy, "busy still high after the last commit");
			end
			@(negedge clock);
			waited++;
		end
		check_cond(name, done_lanes == '1, "a lane never committed its memory access");
		for (int l = 0; l < num_lanes; l++) begin
			if (c.op == op_ld) begin
				model_regs[l][c.dst] = expected[l];
			end
			else begin
				model_mem[addr[l]] = expected[l];
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic test_li_all;
		string name = "li_all_regs";
		int    start_errors;
		start_errors = error_count;
		check_cond(name, commit == '0 && !busy, "commit or busy high after reset");
		for (int r = 0; r < num_regs; r++) begin
			run_alu(name, make_cmd(op_li, r, 0, 0, data_t'($random(seed))));
		end
		finish_test(name, start_errors);
	endtask

	task automatic test_alu_random;
		string name = "alu_random";
		int    start_errors;
		start_errors = error_count;
		for (int i = 0; i < 16; i++) begin
			run_alu(name, make_cmd(random_alu_op(), $random(seed), $random(seed),
				$random(seed), '0));
		end
		finish_test(name, start_errors);
	endtask

	task automatic test_store_load;
		string name = "store_load";
		int    start_errors;
		start_errors = error_count;
		// Base address 8 in lane 0 and 9 in lane 1
		run_alu(name, make_cmd(op_li, 1, 0, 0, 16'd8));
		for (int k = 0; k < 4; k++) begin
			run_alu(name, make_cmd(op_li, 2, 0, 0, data_t'($random(seed))));
			// dst names the base register, which a store must leave intact
			run_mem(name, make_cmd(op_st, 1, 1, 2, data_t'(2 * k)));
		end
		for (int k = 0; k < 4; k++) begin
			run_mem(name, make_cmd(op_ld, 4 + k, 1, 0, data_t'(2 * k)));
		end
		finish_test(name, start_errors);
	endtask

	task automatic test_same_cycle_loads;
		string name = "same_cycle_loads";
		int    start_errors;
		start_errors = error_count;
		// r0 becomes zero in both lanes so both read one address
		run_alu(name, make_cmd(op_xor, 0, 0, 0, '0));
		for (int k = 0; k < 4; k++) begin
			run_mem(name, make_cmd(op_ld, 3, 0, 0, data_t'(8 + 2 * k)));
			run_mem(name, make_cmd(op_ld, 3, 1, 0, data_t'(2 * k + 1)));
		end
		finish_test(name, start_errors);
	endtask

	task automatic test_nop_back_to_back;
		string    name = "nop_back_to_back";
		int       start_errors;
		command_t seq [8];
		data_t    expected [8][num_lanes];
		start_errors = error_count;
		run_alu(name, make_cmd(op_nop, 0, 0, 0, '0));
		for (int i = 0; i < 8; i++) begin
			if (i % 3 == 0) begin
				seq[i] = make_cmd(op_li, $random(seed), 0, 0, data_t'($random(seed)));
			end
			else begin
				seq[i] = make_cmd(random_alu_op(), $random(seed), $random(seed),
					$random(seed), '0);
			end
			for (int l = 0; l < num_lanes; l++) begin
				expected[i][l] = expect_alu(l, seq[i].op, model_regs[l][seq[i].src1],
					model_regs[l][seq[i].src2], seq[i].imm);
				model_regs[l][seq[i].dst] = expected[i][l];
			end
		end
		// One command per falling edge
		// Each commit shows up two falling edges after its command
		@(negedge clock);
		for (int i = 0; i < 10; i++) begin
			if (i >= 2) begin
				check_cond(name, commit == '1, "missing commit in back-to-back run");
				for (int l = 0; l < num_lanes; l++) begin
					check_value(name, l, expected[i - 2][l], commit_data[l]);
				end
			end
			else begin
				check_cond(name, commit == '0, "commit before the run started");
			end
			if (i < 8) begin
				send_cmd(seq[i]);
			end
			else begin
				cmd_valid = 1'b0;
			end
			@(negedge clock);
		end
		check_cond(name, commit == '0, "extra commit after the back-to-back run");
		finish_test(name, start_errors);
	endtask

	initial begin
		seed        = 32'hf76aa10e;
		error_count = 0;
		test_count  = 0;
		reset       = 1'b1;
		cmd_valid   = 1'b0;
		cmd         = '0;
		for (int l = 0; l < num_lanes; l++) begin
			for (int r = 0; r < num_regs; r++) begin
				model_regs[l][r] = '0;
			end
		end
		for (int a = 0; a < mem_depth; a++) begin
			model_mem[a] = '0;
		end
		repeat (16) @(negedge clock);
		reset = 1'b0;

		test_li_all();
		test_alu_random();
		test_store_load();
		test_same_cycle_loads();
		test_nop_back_to_back();

		$display("Summary: %0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end
		else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* build.f */
common/lane_pkg.sv
lane/lane_regfile.sv
lane/lane_exec.sv
lane/lane_unit.sv
source/mem_arbiter.sv
source/data_mem.sv
source/vector_top.sv
bench/vector_chk.sv
bench/vector_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the vector slice testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
	verilator --binary --timing --assert -Wno-fatal --top-module vector_tb \
		-f build.f -o vector_sim > build.log 2>&1 &&
	./obj_dir/vector_sim > sim.log 2>&1
grep -q "^Testbench passed$" sim.log && echo "PASS" ||
	{ echo "FAIL, see build.log and sim.log"; exit 1; }
